// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wall -f flist.f --top-module mem_ctrl_tb -Mdir obj_dir
	./obj_dir/Vmem_ctrl_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
logic/memsys_pkg.sv
logic/dual_port_ram.sv
logic/lane_align.sv
logic/mmio_decode.sv
logic/mem_ctrl.sv
testbench/mem_ctrl_asserts.sv
testbench/mem_ctrl_tb.sv

// File: logic/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
    input  logic        clk,

    // port a, instruction fetch, read only
    input  logic        fetch_en,
    input  logic [31:0] fetch_addr,
    output logic [31:0] fetch_data,

    // port b, data access with per-lane writes
    input  logic        data_en,
    input  logic [3:0]  data_we,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata
);

    import memsys_pkg::*;

    // one array shared by both ports
    logic [31:0] mem [ram_words];

    // word indexes, byte offset bits 1:0 dropped
    logic [ram_idx_w-1:0] fetch_idx;
    logic [ram_idx_w-1:0] data_idx;

    assign fetch_idx = fetch_addr[ram_idx_w+1:2];
    assign data_idx  = data_addr[ram_idx_w+1:2];

    // port a read
    // output register holds its value while fetch_en is low
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_data <= mem[fetch_idx];
        end
    end

    // port b, read and lane writes in the same process
    always_ff @(posedge clk) begin
        if (data_en) begin
            // old word comes out on a write, read-first
            data_rdata <= mem[data_idx];
            for (int i = 0; i < 4; i++) begin
                // each lane written on its own enable
                if (data_we[i]) begin
                    mem[data_idx][8*i +: 8] <= data_wdata[8*i +: 8];
                end
            end
        end
    end

    // a fetch and a write to the same word in one cycle
    // returns the old word on port a as well
    // no collision logic, both ports see the array state before the edge

endmodule

// File: logic/lane_align.sv
`timescale 1ns/1ps

module lane_align (
    input  logic                  clk,
    input  logic                  rst,

    // request from the core
    input  memsys_pkg::dmem_req_t req,

    // raw word from ram port b, valid the cycle after a load
    input  logic [31:0]           ram_rdata,

    // store word with data moved to its lanes
    output logic [31:0]           store_word,

    // load word with the selected lanes at the bottom
    output logic [31:0]           load_word
);

    // lane enables of the last load
    logic [3:0] load_en_q;

    // store placement
    // byte stores take wdata[7:0], halfword stores take wdata[15:0]
    always_comb begin
        case (req.byte_en)
            4'b0001: store_word = {24'h0, req.wdata[7:0]};
            4'b0010: store_word = {16'h0, req.wdata[7:0], 8'h0};
            4'b0100: store_word = {8'h0, req.wdata[7:0], 16'h0};
            4'b1000: store_word = {req.wdata[7:0], 24'h0};
            // halfword pairs
            4'b0011: store_word = {16'h0, req.wdata[15:0]};
            4'b0110: store_word = {8'h0, req.wdata[15:0], 8'h0};
            4'b1100: store_word = {req.wdata[15:0], 16'h0};
            // full word and any odd pattern
            default: store_word = req.wdata;
        endcase
    end

    // capture lane enables when a load is presented
    // cleared to zero, which extracts the whole word
    always_ff @(posedge clk) begin
        if (rst) begin
            load_en_q <= 4'b0000;
        end else if (req.rea) begin
            load_en_q <= req.byte_en;
        end
    end

    // load extraction one cycle later, zero extended
    always_comb begin
        case (load_en_q)
            4'b0001: load_word = {24'h0, ram_rdata[7:0]};
            4'b0010: load_word = {24'h0, ram_rdata[15:8]};
            4'b0100: load_word = {24'h0, ram_rdata[23:16]};
            4'b1000: load_word = {24'h0, ram_rdata[31:24]};
            // halfword pairs
            4'b0011: load_word = {16'h0, ram_rdata[15:0]};
            4'b0110: load_word = {16'h0, ram_rdata[23:8]};
            4'b1100: load_word = {16'h0, ram_rdata[31:16]};
            // full word
            default: load_word = ram_rdata;
        endcase
    end

    // back to back loads work because ram_rdata and load_en_q
    // advance together, one stage each

endmodule

// File: logic/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                  clk,
    input  logic                  rst,

    // instruction fetch
    input  logic                  imem_en,
    input  logic [31:0]           imem_addr,
    output logic [31:0]           imem_dout,

    // data access
    input  memsys_pkg::dmem_req_t req,
    output logic [31:0]           mem_dout,

    // peripherals
    output memsys_pkg::mmio_out_t mmio_o,
    input  memsys_pkg::mmio_in_t  mmio_i
);

    // decode result
    logic        ram_sel;

    // ram port b controls
    logic        ram_en;
    logic [3:0]  ram_we;

    // data paths around the ram
    logic [31:0] store_word;
    logic [31:0] ram_rdata;
    logic [31:0] load_word;

    // port b runs only for accesses that land in ram
    assign ram_en = (req.rea || req.wea) && ram_sel;
    // lane writes gated by the store strobe and the region
    assign ram_we = (req.wea && ram_sel) ? req.byte_en : 4'b0000;

    // region decode, i/o strobes, readback select
    mmio_decode mmio_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .load_word (load_word),
        .mmio_i    (mmio_i),
        .ram_sel   (ram_sel),
        .mmio_o    (mmio_o),
        .mem_dout  (mem_dout)
    );

    // store lane placement and load lane extraction
    lane_align lane_align_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ram_rdata  (ram_rdata),
        .store_word (store_word),
        .load_word  (load_word)
    );

    // shared instruction and data memory
    // port a for fetch, port b for loads and stores
    dual_port_ram dual_port_ram_inst (
        .clk        (clk),
        .fetch_en   (imem_en),
        .fetch_addr (imem_addr),
        .fetch_data (imem_dout),
        .data_en    (ram_en),
        .data_we    (ram_we),
        .data_addr  (req.addr),
        .data_wdata (store_word),
        .data_rdata (ram_rdata)
    );

endmodule

// File: logic/memsys_pkg.sv
package memsys_pkg;

    // upper address bits 31:12 that select the i/o page
    localparam logic [19:0] mmio_page = 20'haaaaa;

    // device offsets inside the i/o page, address bits 11:0
    localparam logic [11:0] uart_data_off = 12'h400;
    // status byte holds tx_full in bit1 and rx_data_present in bit0
    localparam logic [11:0] uart_stat_off = 12'h404;
    localparam logic [11:0] disp_off = 12'h008;

    // shared ram depth in 32-bit words
    localparam int ram_words = 2048;
    // word index width, taken from address bits 12:2
    localparam int ram_idx_w = $clog2(ram_words);

    // data request from the core
    typedef struct packed {
        // read strobe, level
        logic        rea;
        // write strobe, level
        logic        wea;
        // lane enables, bit0 is the lowest byte
        logic [3:0]  byte_en;
        // byte address
        logic [31:0] addr;
        // store data, low byte or halfword for partial stores
        logic [31:0] wdata;
    } dmem_req_t;

    // strobes and data toward the peripherals
    typedef struct packed {
        // uart transmit write
        logic        tx_wen;
        // uart receive read, pops the rx fifo
        logic        rx_ren;
        // byte handed to the uart transmitter
        logic [7:0]  uart_din;
        // display register write
        logic        disp_wea;
        // full word for the display register
        logic [31:0] disp_dat;
    } mmio_out_t;

    // signals back from the peripherals
    typedef struct packed {
        // head of the uart receive fifo
        logic [7:0]  uart_dout;
        // transmitter cannot take another byte
        logic        tx_full;
        // at least one received byte waiting
        logic        rx_data_present;
    } mmio_in_t;

endpackage

// File: logic/mmio_decode.sv
`timescale 1ns/1ps

module mmio_decode (
    input  logic                  clk,
    input  logic                  rst,

    // request from the core
    input  memsys_pkg::dmem_req_t req,

    // aligned ram load word from lane_align
    input  logic [31:0]           load_word,

    // peripheral side
    input  memsys_pkg::mmio_in_t  mmio_i,

    // high for addresses below the i/o page
    output logic                  ram_sel,
    output memsys_pkg::mmio_out_t mmio_o,

    // load data back to the core
    output logic [31:0]           mem_dout
);

    import memsys_pkg::*;

    // address split
    logic [19:0] addr_hi;
    logic [11:0] addr_lo;

    // region and device hits
    logic mmio_region;
    logic uart_data_hit;
    logic uart_stat_hit;
    logic disp_hit;

    // registered readback select
    logic        uart_rd_q;
    logic [11:0] uart_off_q;

    assign addr_hi = req.addr[31:12];
    assign addr_lo = req.addr[11:0];

    // anything above the page belongs to neither target
    assign ram_sel     = (addr_hi < mmio_page);
    assign mmio_region = (addr_hi == mmio_page);

    assign uart_data_hit = mmio_region && (addr_lo == uart_data_off);
    assign uart_stat_hit = mmio_region && (addr_lo == uart_stat_off);
    assign disp_hit      = mmio_region && (addr_lo == disp_off);

    // peripheral strobes, same cycle as the request
    always_comb begin
        mmio_o = '0;
        if (uart_data_hit) begin
            mmio_o.tx_wen   = req.wea;
            mmio_o.rx_ren   = req.rea;
            mmio_o.uart_din = req.wdata[7:0];
        end
        if (disp_hit) begin
            mmio_o.disp_wea = req.wea;
            mmio_o.disp_dat = req.wdata;
        end
    end

    // remember a uart load for the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            uart_rd_q <= 1'b0;
        end else begin
            uart_rd_q <= req.rea && (uart_data_hit || uart_stat_hit);
        end
    end

    // offset only matters while uart_rd_q is high
    always_ff @(posedge clk) begin
        if (uart_data_hit || uart_stat_hit) begin
            uart_off_q <= addr_lo;
        end
    end

    // readback mux
    // uart values are live, sampled in the cycle after the load
    always_comb begin
        if (!uart_rd_q) begin
            mem_dout = load_word;
        end else if (uart_off_q == uart_stat_off) begin
            mem_dout = {30'h0, mmio_i.tx_full, mmio_i.rx_data_present};
        end else begin
            mem_dout = {24'h0, mmio_i.uart_dout};
        end
    end

endmodule

// File: testbench/mem_ctrl_asserts.sv
`timescale 1ns/1ps

module mem_ctrl_asserts (
    input logic                  clk,
    input logic                  rst,
    input memsys_pkg::dmem_req_t req,
    input logic                  ram_en,
    input logic [3:0]            ram_we,
    input memsys_pkg::mmio_out_t mmio_o
);

    import memsys_pkg::*;

    // i/o and out of range stores never reach the ram
    no_ram_write_outside: assert property (@(posedge clk) disable iff (rst)
        (req.addr[31:12] >= mmio_page) |-> (ram_we == 4'b0000))
    else $error("ram lane write outside the ram region");

    // port b only runs for ram addresses
    ram_en_in_region: assert property (@(posedge clk) disable iff (rst)
        ram_en |-> (req.addr[31:12] < mmio_page))
    else $error("ram port enabled outside the ram region");

    // a ram store runs the port and writes exactly the requested lanes
    ram_store_lanes: assert property (@(posedge clk) disable iff (rst)
        (req.wea && (req.addr[31:12] < mmio_page)) |-> (ram_en && (ram_we == req.byte_en)))
    else $error("ram store did not write the requested lanes");

    // uart strobes only at the uart data offset of the i/o page
    tx_at_uart_data: assert property (@(posedge clk) disable iff (rst)
        mmio_o.tx_wen |-> (req.wea && (req.addr == {mmio_page, uart_data_off})))
    else $error("uart transmit strobe without a store to the uart data offset");

    rx_at_uart_data: assert property (@(posedge clk) disable iff (rst)
        mmio_o.rx_ren |-> (req.rea && (req.addr == {mmio_page, uart_data_off})))
    else $error("uart receive strobe without a load from the uart data offset");

    // display strobe only at the display offset
    disp_at_offset: assert property (@(posedge clk) disable iff (rst)
        mmio_o.disp_wea |-> (req.wea && (req.addr == {mmio_page, disp_off})))
    else $error("display strobe without a store to the display offset");

endmodule

bind mem_ctrl mem_ctrl_asserts mem_ctrl_asserts_inst (.*);

// File: testbench/mem_ctrl_tb.sv
`timescale 1ns/1ps

module mem_ctrl_tb;

    import memsys_pkg::*;

    logic        clk;
    logic        rst;
    logic        imem_en;
    logic [31:0] imem_addr;
    logic [31:0] imem_dout;
    dmem_req_t   req;
    logic [31:0] mem_dout;
    mmio_out_t   mmio_o;
    mmio_in_t    mmio_i;

    // expected values, registered together with the request
    logic        ld_chk;
    logic [31:0] ld_exp;
    logic        f_chk;
    logic [31:0] f_exp;
    mmio_out_t   mmio_exp;

    // byte shadow of the ram, address bits 12:0
    logic [7:0]  ram_model [8192];

    // uart stub registers
    logic [7:0]  stub_rx_byte;
    logic        stub_tx_full = 1'b0;
    logic        stub_rx_present = 1'b1;
    int          stub_tx_count;

    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          errs_mark;
    logic [31:0] addrs [16];
    logic [3:0]  lane_pats [7];

    mem_ctrl mem_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_en   (imem_en),
        .imem_addr (imem_addr),
        .imem_dout (imem_dout),
        .req       (req),
        .mem_dout  (mem_dout),
        .mmio_o    (mmio_o),
        .mmio_i    (mmio_i)
    );

    always #4 clk = ~clk;

    assign mmio_i = {stub_rx_byte, stub_tx_full, stub_rx_present};

    // stub reacts to the strobes at the edge that ends the access
    always @(posedge clk) begin
        if (rst) begin
            stub_tx_full    <= 1'b0;
            stub_rx_present <= 1'b1;
            stub_tx_count   <= 0;
        end else begin
            if (mmio_o.tx_wen) begin
                stub_tx_full  <= ~stub_tx_full;
                stub_tx_count <= stub_tx_count + 1;
            end
            if (mmio_o.rx_ren) begin
                stub_rx_present <= ~stub_rx_present;
            end
        end
    end

    // load data one cycle after the request
    load_data_check: assert property (@(posedge clk) disable iff (rst)
        ld_chk |=> (mem_dout == $past(ld_exp)))
    else begin
        errors++;
        $display("error at %0t: mem_dout %h, expected %h",
                 $time, $sampled(mem_dout), $past(ld_exp));
    end

    // fetch word one cycle after imem_en
    fetch_data_check: assert property (@(posedge clk) disable iff (rst)
        f_chk |=> (imem_dout == $past(f_exp)))
    else begin
        errors++;
        $display("error at %0t: imem_dout %h, expected %h",
                 $time, $sampled(imem_dout), $past(f_exp));
    end

    // peripheral strobes and data in the request cycle
    mmio_out_check: assert property (@(posedge clk) disable iff (rst)
        mmio_o == mmio_exp)
    else begin
        errors++;
        $display("error at %0t: mmio_o %h, expected %h",
                 $time, $sampled(mmio_o), $sampled(mmio_exp));
    end

    function automatic logic is_ram(input logic [31:0] addr);
        return addr[31:12] < mmio_page;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [12:0] base;
        base = {addr[12:2], 2'b00};
        return {ram_model[base+3], ram_model[base+2], ram_model[base+1], ram_model[base]};
    endfunction

    // lowest enabled lane
    function automatic int low_lane(input logic [3:0] be);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    // true for the seven byte and halfword patterns
    function automatic logic partial(input logic [3:0] be);
        return be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b0110, 4'b1100};
    endfunction

    function automatic logic [31:0] load_expect(input logic [3:0] be, input logic [31:0] w);
        logic [31:0] shifted;
        if (!partial(be)) begin
            return w;
        end
        shifted = w >> (8 * low_lane(be));
        // one lane set means a byte, two means a halfword
        if ($countones(be) == 1) begin
            return {24'h0, shifted[7:0]};
        end
        return {16'h0, shifted[15:0]};
    endfunction

    task automatic store_model(input logic [3:0] be, input logic [31:0] addr,
                               input logic [31:0] wdata);
        logic [31:0] placed;
        logic [12:0] base;
        placed = partial(be) ? (wdata << (8 * low_lane(be))) : wdata;
        base = {addr[12:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                ram_model[base+i] = placed[8*i +: 8];
            end
        end
    endtask

    function automatic mmio_out_t expect_mmio(input dmem_req_t r);
        mmio_out_t m;
        m = '0;
        if (r.addr[31:12] == mmio_page && r.addr[11:0] == uart_data_off) begin
            m.tx_wen   = r.wea;
            m.rx_ren   = r.rea;
            m.uart_din = r.wdata[7:0];
        end
        if (r.addr[31:12] == mmio_page && r.addr[11:0] == disp_off) begin
            m.disp_wea = r.wea;
            m.disp_dat = r.wdata;
        end
        return m;
    endfunction

    // one cycle of stimulus on both ports
    task automatic access(input logic rd, input logic wr, input logic [3:0] be,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic fen, input logic [31:0] faddr);
        dmem_req_t r;
        r.rea     = rd;
        r.wea     = wr;
        r.byte_en = be;
        r.addr    = addr;
        r.wdata   = wdata;
        @(posedge clk);
        req       <= r;
        imem_en   <= fen;
        imem_addr <= faddr;
        mmio_exp  <= expect_mmio(r);
        f_chk     <= fen;
        f_exp     <= model_word(faddr);
        ld_chk    <= 1'b0;
        if (fen) begin
            checks++;
        end
        if (rd && is_ram(addr)) begin
            ld_chk <= 1'b1;
            ld_exp <= load_expect(be, model_word(addr));
            checks++;
        end else if (rd && addr[31:12] == mmio_page && addr[11:0] == uart_data_off) begin
            ld_chk <= 1'b1;
            ld_exp <= {24'h0, stub_rx_byte};
            checks++;
        end else if (rd && addr[31:12] == mmio_page && addr[11:0] == uart_stat_off) begin
            ld_chk <= 1'b1;
            ld_exp <= {30'h0, stub_tx_full, stub_rx_present};
            checks++;
        end
        if (wr && is_ram(addr)) begin
            store_model(be, addr, wdata);
        end
    endtask

    task automatic idle();
        access(1'b0, 1'b0, 4'b0000, 32'h0, 32'h0, 1'b0, 32'h0);
    endtask

    // run idle cycles until no check is pending, then report the test
    task automatic finish_test(input string name);
        int t;
        t = 0;
        while ((ld_chk || f_chk) && t < 20) begin
            idle();
            t++;
        end
        if (t >= 20) begin
            $display("timeout: load and fetch checks never drained in test %s", name);
            $display("Checks failed");
            $finish;
        end else begin
            idle();
            idle();
            tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - errs_mark);
            errs_mark = errors;
        end
    endtask

    // waits for the stub to take a transmitted byte
    task automatic wait_tx(input int count_before);
        int t;
        t = 0;
        while (stub_tx_count == count_before && t < 10) begin
            idle();
            t++;
        end
        if (t >= 10) begin
            $display("timeout: uart stub never saw a transmit write");
            $display("Checks failed");
            $finish;
        end
    endtask

    initial begin
        int n;
        logic [31:0] w;
        clk = 1'b0;
        rst = 1'b1;
        imem_en = 1'b0;
        imem_addr = 32'h0;
        req = '0;
        ld_chk = 1'b0;
        ld_exp = 32'h0;
        f_chk = 1'b0;
        f_exp = 32'h0;
        mmio_exp = '0;
        stub_rx_byte = 8'h5a;
        seed = 32'h8861_b67e;
        errors = 0;
        checks = 0;
        tests = 0;
        errs_mark = 0;
        lane_pats = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b0110, 4'b1100};
        for (int i = 0; i < 8192; i++) begin
            ram_model[i] = 8'h00;
        end
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        // full words, stores then back to back loads
        for (int i = 0; i < 16; i++) begin
            addrs[i] = {19'h0, 11'($random(seed)), 2'b00};
            access(1'b0, 1'b1, 4'b1111, addrs[i], $random(seed), 1'b0, 32'h0);
        end
        for (int i = 0; i < 16; i++) begin
            access(1'b1, 1'b0, 4'b1111, addrs[i], 32'h0, 1'b0, 32'h0);
        end
        finish_test("full word round trip");

        // each lane pattern on a fresh word
        for (int p = 0; p < 7; p++) begin
            w = {19'h0, 11'h600 + p[10:0], 2'b00};
            access(1'b0, 1'b1, 4'b1111, w, $random(seed), 1'b0, 32'h0);
            access(1'b0, 1'b1, lane_pats[p], w, $random(seed), 1'b0, 32'h0);
            access(1'b1, 1'b0, lane_pats[p], w, 32'h0, 1'b0, 32'h0);
            access(1'b1, 1'b0, 4'b1111, w, 32'h0, 1'b0, 32'h0);
        end
        finish_test("byte and halfword lanes");

        // fetch alongside data loads and stores
        for (int i = 0; i < 16; i++) begin
            n = (i + 5) % 16;
            if (i % 2 == 0) begin
                access(1'b1, 1'b0, 4'b1111, addrs[n], 32'h0, 1'b1, addrs[i]);
            end else begin
                access(1'b0, 1'b1, 4'b1111, addrs[n], $random(seed), 1'b1, addrs[i]);
            end
        end
        for (int i = 0; i < 16; i++) begin
            access(1'b0, 1'b0, 4'b0000, 32'h0, 32'h0, 1'b1, addrs[i]);
        end
        finish_test("instruction fetch");

        // word 0x400 aliases the uart offset in its low bits
        access(1'b0, 1'b1, 4'b1111, 32'h0000_0400, 32'hcafe_f00d, 1'b0, 32'h0);
        n = stub_tx_count;
        access(1'b0, 1'b1, 4'b1111, 32'haaaa_a400, $random(seed), 1'b0, 32'h0);
        wait_tx(n);
        access(1'b1, 1'b0, 4'b1111, 32'h0000_0400, 32'h0, 1'b0, 32'h0);
        access(1'b1, 1'b0, 4'b1111, 32'haaaa_a400, 32'h0, 1'b0, 32'h0);
        idle();
        access(1'b1, 1'b0, 4'b1111, 32'h0000_0400, 32'h0, 1'b0, 32'h0);
        finish_test("uart strobes");

        // readback of data and status, then back to back with ram
        for (int i = 0; i < 4; i++) begin
            stub_rx_byte <= 8'($random(seed));
            idle();
            access(1'b1, 1'b0, 4'b1111, 32'haaaa_a400, 32'h0, 1'b0, 32'h0);
            idle();
            access(1'b1, 1'b0, 4'b1111, 32'haaaa_a404, 32'h0, 1'b0, 32'h0);
            access(1'b1, 1'b0, 4'b1111, addrs[i], 32'h0, 1'b0, 32'h0);
        end
        finish_test("uart readback");

        // display write and accesses that leave mmio_o quiet
        access(1'b0, 1'b1, 4'b1111, 32'haaaa_a008, $random(seed), 1'b0, 32'h0);
        access(1'b0, 1'b1, 4'b1111, 32'haaaa_a004, $random(seed), 1'b0, 32'h0);
        access(1'b0, 1'b1, 4'b1111, 32'haaaa_a00c, $random(seed), 1'b0, 32'h0);
        access(1'b0, 1'b1, 4'b1111, 32'hbbbb_b400, $random(seed), 1'b0, 32'h0);
        access(1'b1, 1'b0, 4'b1111, 32'hbbbb_b008, 32'h0, 1'b0, 32'h0);
        access(1'b0, 1'b1, 4'b1111, addrs[3], $random(seed), 1'b0, 32'h0);
        access(1'b1, 1'b0, 4'b1111, addrs[3], 32'h0, 1'b0, 32'h0);
        finish_test("display and quiet strobes");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
